// ==== include/exec_config.svh ====
/* Sizing macros for the execute stage
   Pulled in by the package and by every RTL file that needs a width or a depth */

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Integer register and data path width
// RV32 only, the branch link offset assumes 4-byte instructions
`define XLEN 32

// Entries in the write-back FIFO
// Must be a power of two of 2 or more, since the pointers wrap naturally
// Bounds how many instructions can wait for write-back at once
`define WB_FIFO_DEPTH 4

`endif

// ==== rtl/exec_pkg.sv ====
/* Types shared across the execute stage: unit selection, command encodings
   and the structs carried on the issue, request, result and write-back paths */

`include "exec_config.svh"

package exec_pkg;

  // Which unit executes the instruction
  typedef enum logic [1:0] {
    unit_none = 2'd0,  // Write-back bookkeeping only
    unit_alu  = 2'd1,
    unit_bru  = 2'd2
  } unit_sel_e;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_sll = 4'd5,
    alu_srl = 4'd6,  // Logical right shift
    alu_slt = 4'd7   // Signed compare
  } alu_op_e;

  // Branch unit operations
  typedef enum logic [3:0] {
    bru_beq = 4'd0,
    bru_bne = 4'd1,
    bru_blt = 4'd2,
    bru_bge = 4'd3,
    bru_jal = 4'd4   // Unconditional
  } bru_op_e;

  // One command word, decoded by whichever unit the instruction targets
  typedef union packed {
    alu_op_e alu;
    bru_op_e bru;
  } exec_cmd_u;

  typedef struct packed {
    logic rs1;  // Take forwarded value for operand 1
    logic rs2;  // Same for operand 2
  } fwd_flags_t;

  // Decoded instruction from the register-file stage
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    unit_sel_e        unit;
    exec_cmd_u        cmd;
    fwd_flags_t       fwd;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] imm;
  } issue_t;

  typedef struct packed {
    exec_cmd_u        cmd;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
  } alu_req_t;

  typedef struct packed {
    exec_cmd_u        cmd;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;  // Branch offset
  } bru_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] result;
  } alu_res_t;

  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;  // pc + imm
    logic [`XLEN-1:0] link;    // Return address
  } bru_res_t;

  // What write-back needs to retire one instruction
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    unit_sel_e        unit;
  } wb_entry_t;

endpackage

// ==== rtl/wb_fifo.sv ====
/* Synchronous FIFO with valid/ready on both sides and a flush input
   Holds write-back bookkeeping in issue order until write-back pops it */

`timescale 1ns/1ps
`include "exec_config.svh"

module wb_fifo
  import exec_pkg::*;
#(
  parameter int depth = `WB_FIFO_DEPTH
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push_valid,
  input  wb_entry_t push,
  output logic      push_ready,
  output logic      pop_valid,
  output wb_entry_t pop,
  input  logic      pop_ready,
  input  logic      flush       // Drops everything, including a same-cycle push
);

  localparam int ptr_w = $clog2(depth);

  wb_entry_t        mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w:0]   count;
  logic             push_fire;
  logic             pop_fire;

  assign push_ready = (count != (ptr_w+1)'(depth));
  assign pop_valid  = (count != '0);
  assign pop        = mem[rd_ptr];

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push_fire && !flush) begin
      mem[wr_ptr] <= push;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop_fire)  rd_ptr <= rd_ptr + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (ptr_w+1)'(depth))
    else $error("FIFO count above depth");

  // Head entry held while write-back stalls
  a_pop_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready && !flush) |=> (pop_valid && $stable(pop)))
    else $error("FIFO head changed while stalled");

endmodule

// ==== rtl/alu.sv ====
/* Integer ALU with one register stage
   A request pulse gives a result strobe exactly one cycle later */

`timescale 1ns/1ps
`include "exec_config.svh"

module alu
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  alu_req_t req,
  output logic     res_valid,
  output alu_res_t res
);

  logic [4:0]       shamt;
  logic             lt;
  logic [`XLEN-1:0] result;

  always_comb begin
    shamt = req.op2[4:0];                         // RV32 shift amount
    lt    = $signed(req.op1) < $signed(req.op2);
    case (req.cmd.alu)
      alu_add: result = req.op1 + req.op2;
      alu_sub: result = req.op1 - req.op2;
      alu_and: result = req.op1 & req.op2;
      alu_or:  result = req.op1 | req.op2;
      alu_xor: result = req.op1 ^ req.op2;
      alu_sll: result = req.op1 << shamt;
      alu_srl: result = req.op1 >> shamt;
      alu_slt: result = {{(`XLEN-1){1'b0}}, lt};
      default: result = '0;                       // Unused encodings
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= req_valid;
    end
  end

  // Result only loads on a request
  always_ff @(posedge clk) begin
    if (req_valid) begin
      res.result <= result;
    end
  end

endmodule

// ==== rtl/branch_unit.sv ====
/* Branch unit: resolves the condition, target and link address of a branch
   or jump, registered, with a result strobe one cycle after the request */

`timescale 1ns/1ps
`include "exec_config.svh"

module branch_unit
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  bru_req_t req,
  output logic     res_valid,
  output bru_res_t res
);

  logic             eq;
  logic             lt;
  logic             taken;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] link;

  always_comb begin
    eq = (req.op1 == req.op2);
    lt = $signed(req.op1) < $signed(req.op2);
    case (req.cmd.bru)
      bru_beq: taken = eq;
      bru_bne: taken = !eq;
      bru_blt: taken = lt;
      bru_bge: taken = !lt;
      bru_jal: taken = 1'b1;
      default: taken = 1'b0;
    endcase
    target = req.pc + req.imm;
    link   = req.pc + `XLEN'(4);  // Next sequential pc
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      res.taken  <= taken;
      res.target <= target;
      res.link   <= link;
    end
  end

  // Back-to-back outcomes need back-to-back requests
  a_no_stretch: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && $past(res_valid)) |-> $past(req_valid))
    else $error("Branch outcome strobe held without a new request");

endmodule

// ==== rtl/dispatcher.sv ====
/* Execute dispatcher that applies operand forwarding, starts the ALU or branch unit
   on each accepted issue and queues the retire bookkeeping toward write-back */

`timescale 1ns/1ps
`include "exec_config.svh"

module dispatcher
  import exec_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_valid,
  input  issue_t           issue,
  input  logic [`XLEN-1:0] fwd_data,   // Level from write-back
  input  logic             invalidate,
  input  logic             wb_ready,
  output logic             issue_ready,
  output logic             alu_req_valid,
  output alu_req_t         alu_req,
  output logic             bru_req_valid,
  output bru_req_t         bru_req,
  output logic             wb_valid,
  output wb_entry_t        wb
);

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic             accept;
  wb_entry_t        wb_push;

  // Operand selection
  always_comb begin
    op1 = issue.fwd.rs1 ? fwd_data : issue.op1;
    op2 = issue.fwd.rs2 ? fwd_data : issue.op2;
  end

  // Ready follows the write-back FIFO only
  assign accept = issue_valid && issue_ready;

  always_comb begin
    alu_req.cmd = issue.cmd;
    alu_req.op1 = op1;
    alu_req.op2 = op2;

    bru_req.cmd = issue.cmd;
    bru_req.op1 = op1;
    bru_req.op2 = op2;
    bru_req.pc  = issue.pc;
    bru_req.imm = issue.imm;

    // One-cycle start pulse to the selected unit
    alu_req_valid = accept && (issue.unit == unit_alu);
    bru_req_valid = accept && (issue.unit == unit_bru);

    wb_push.pc   = issue.pc;
    wb_push.rd   = issue.rd;
    wb_push.unit = issue.unit;
  end

  wb_fifo #(
    .depth(`WB_FIFO_DEPTH)
  ) u_wb_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (issue_valid),
    .push       (wb_push),
    .push_ready (issue_ready),
    .pop_valid  (wb_valid),
    .pop        (wb),
    .pop_ready  (wb_ready),
    .flush      (invalidate)
  );

  // At most one unit started per instruction
  a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_req_valid && bru_req_valid))
    else $error("ALU and branch unit started in the same cycle");

endmodule

// ==== rtl/exec_stage.sv ====
/* Top of the execute stage: dispatcher with its write-back FIFO, ALU and branch unit
   Fed by the register-file stage, drains into write-back */

`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage
  import exec_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_valid,
  input  issue_t           issue,
  input  logic [`XLEN-1:0] fwd_data,
  output logic             issue_ready,
  input  logic             invalidate,
  input  logic             wb_ready,
  output logic             alu_valid,
  output alu_res_t         alu_res,
  output logic             bru_valid,
  output bru_res_t         bru_res,
  output logic             wb_valid,
  output wb_entry_t        wb
);

  logic     alu_req_valid;
  alu_req_t alu_req;
  logic     bru_req_valid;
  bru_req_t bru_req;

  dispatcher u_dispatcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .fwd_data      (fwd_data),
    .invalidate    (invalidate),
    .wb_ready      (wb_ready),
    .issue_ready   (issue_ready),
    .alu_req_valid (alu_req_valid),
    .alu_req       (alu_req),
    .bru_req_valid (bru_req_valid),
    .bru_req       (bru_req),
    .wb_valid      (wb_valid),
    .wb            (wb)
  );

  alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (alu_req_valid),
    .req       (alu_req),
    .res_valid (alu_valid),
    .res       (alu_res)
  );

  branch_unit u_branch_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (bru_req_valid),
    .req       (bru_req),
    .res_valid (bru_valid),
    .res       (bru_res)
  );

endmodule

// ==== bench/exec_stage_tb.sv ====
/* Testbench for the execute stage: random ALU, branch and bookkeeping-only instructions
   checked against a reference model, with write-back back-pressure and invalidate */

`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage_tb
  import exec_pkg::*;
;

  localparam int n_alu    = 64;
  localparam int n_fwd    = 48;
  localparam int n_branch = 5 * 3 * 3;  // Ops x relations x repeats
  localparam int n_mix    = 40;
  localparam int n_total  = n_alu + n_fwd + n_branch + 2 * n_mix + `WB_FIFO_DEPTH + 1 + 12;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             issue_valid;
  issue_t           issue;
  logic [`XLEN-1:0] fwd_data;
  logic             issue_ready;
  logic             invalidate;
  logic             wb_ready;
  logic             alu_valid;
  alu_res_t         alu_res;
  logic             bru_valid;
  bru_res_t         bru_res;
  logic             wb_valid;
  wb_entry_t        wb;

  alu_res_t  alu_q[$];
  bru_res_t  bru_q[$];
  wb_entry_t wb_q[$];
  int        alu_t[$];   // Accept cycle of each queued ALU result
  int        bru_t[$];
  int        cyc = 0;
  int        wb_mode = 0;  // 0 ready, 1 random, 2 stalled

  exec_stage u_exec_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue       (issue),
    .fwd_data    (fwd_data),
    .issue_ready (issue_ready),
    .invalidate  (invalidate),
    .wb_ready    (wb_ready),
    .alu_valid   (alu_valid),
    .alu_res     (alu_res),
    .bru_valid   (bru_valid),
    .bru_res     (bru_res),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("FAIL: see errors above");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input logic [159:0] got, input logic [159:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  // Expected unit results and retire entry for one instruction
  function automatic void model_exec(input issue_t ins, input logic [`XLEN-1:0] fwd,
                                     output alu_res_t ar, output bru_res_t br,
                                     output wb_entry_t we);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             lt;
    a  = ins.fwd.rs1 ? fwd : ins.op1;
    b  = ins.fwd.rs2 ? fwd : ins.op2;
    lt = $signed(a) < $signed(b);
    case (ins.cmd.alu)
      alu_add: ar.result = a + b;
      alu_sub: ar.result = a - b;
      alu_and: ar.result = a & b;
      alu_or:  ar.result = a | b;
      alu_xor: ar.result = a ^ b;
      alu_sll: ar.result = a << b[4:0];
      alu_srl: ar.result = a >> b[4:0];
      alu_slt: ar.result = {{(`XLEN-1){1'b0}}, lt};
      default: ar.result = '0;
    endcase
    case (ins.cmd.bru)
      bru_beq: br.taken = (a == b);
      bru_bne: br.taken = (a != b);
      bru_blt: br.taken = lt;
      bru_bge: br.taken = !lt;
      bru_jal: br.taken = 1'b1;
      default: br.taken = 1'b0;
    endcase
    br.target = ins.pc + ins.imm;
    br.link   = ins.pc + `XLEN'(4);
    we.pc     = ins.pc;
    we.rd     = ins.rd;
    we.unit   = ins.unit;
  endfunction

  // rel 0 equal, 1 op1 below op2, 2 op1 above op2 (signed)
  function automatic issue_t make_branch(input bru_op_e op, input int rel);
    issue_t           ins;
    logic [`XLEN-1:0] tmp;
    ins      = '0;
    ins.pc   = $urandom & 32'hffff_fffc;
    ins.rd   = 5'($urandom);
    ins.imm  = $urandom;
    ins.op1  = $urandom;
    ins.op2  = (rel == 0) ? ins.op1 : $urandom;
    if (rel != 0 && ((rel == 1) != ($signed(ins.op1) < $signed(ins.op2)))) begin
      tmp     = ins.op1;
      ins.op1 = ins.op2;
      ins.op2 = tmp;
    end
    ins.cmd.bru = op;
    ins.unit    = unit_bru;
    return ins;
  endfunction

  function automatic issue_t rand_issue(input unit_sel_e u, input bit use_fwd);
    issue_t ins;
    if (u == unit_bru) begin
      ins = make_branch(bru_op_e'(4'($urandom_range(0, 4))), int'($urandom_range(0, 2)));
    end else begin
      ins         = '0;
      ins.pc      = $urandom & 32'hffff_fffc;
      ins.rd      = 5'($urandom);
      ins.op1     = $urandom;
      ins.op2     = $urandom;
      ins.imm     = $urandom;
      ins.cmd.alu = alu_op_e'(4'($urandom_range(0, 7)));
    end
    ins.unit    = u;
    ins.fwd.rs1 = use_fwd && ($urandom_range(0, 1) == 1);
    ins.fwd.rs2 = use_fwd && ($urandom_range(0, 1) == 1);
    return ins;
  endfunction

  function automatic unit_sel_e any_unit();
    return unit_sel_e'(2'($urandom_range(0, 2)));
  endfunction

  // Holds the instruction until accepted, queueing what should come back
  task automatic issue_one(input issue_t ins, input logic [`XLEN-1:0] fwd, input bit inval);
    alu_res_t  ea;
    bru_res_t  eb;
    wb_entry_t ew;
    bit        took;
    model_exec(ins, fwd, ea, eb, ew);
    took = 1'b0;
    @(negedge clk);
    issue_valid = 1'b1;
    issue       = ins;
    fwd_data    = fwd;
    invalidate  = inval;
    while (!took) begin
      took = issue_ready;  // Follows the FIFO count, settled since the last edge
      @(posedge clk);
      if (took) begin
        if (ins.unit == unit_alu) begin
          alu_q.push_back(ea);
          alu_t.push_back(cyc);
        end
        if (ins.unit == unit_bru) begin
          bru_q.push_back(eb);
          bru_t.push_back(cyc);
        end
        if (!invalidate) wb_q.push_back(ew);  // Dropped by a same-cycle flush
      end else begin
        @(negedge clk);
        invalidate = 1'b0;
      end
    end
  endtask

  task automatic stop_issue();
    @(negedge clk);
    issue_valid = 1'b0;
    invalidate  = 1'b0;
  endtask

  task automatic set_wb_mode(input int m);
    @(posedge clk);
    wb_mode = m;
  endtask

  task automatic pulse_invalidate();
    @(negedge clk);
    issue_valid = 1'b0;
    invalidate  = 1'b1;
    @(negedge clk);
    invalidate = 1'b0;
    check(160'(wb_valid), 160'(1'b0), "wb_valid after invalidate");
  endtask

  task automatic drain();
    stop_issue();
    set_wb_mode(0);
    while (alu_q.size() != 0 || bru_q.size() != 0 || wb_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // Write-back side
  initial begin
    wb_ready = 1'b1;
    forever begin
      @(negedge clk);
      case (wb_mode)
        0:       wb_ready = 1'b1;
        1:       wb_ready = ($urandom_range(0, 1) == 1);
        default: wb_ready = 1'b0;
      endcase
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (alu_valid) begin
        if (alu_q.size() == 0) abort_run("ALU strobe with no ALU instruction outstanding");
        else begin
          check(160'(alu_res), 160'(alu_q.pop_front()), "ALU result");
          check(160'(cyc), 160'(alu_t.pop_front() + 1), "ALU strobe timing");
        end
      end
      if (bru_valid) begin
        if (bru_q.size() == 0) abort_run("Branch strobe with no branch outstanding");
        else begin
          check(160'(bru_res), 160'(bru_q.pop_front()), "branch outcome");
          check(160'(cyc), 160'(bru_t.pop_front() + 1), "branch strobe timing");
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (wb_valid && wb_ready) begin
        if (wb_q.size() == 0) abort_run("Write-back entry popped with none expected");
        else check(160'(wb), 160'(wb_q.pop_front()), "write-back entry");
      end
      if (invalidate) wb_q.delete();
    end
  end

  initial begin
    repeat (n_total * 40 + 200) @(posedge clk);
    abort_run("Watchdog expired before the tests finished");
  end

  initial begin
    issue_t ins;
    void'($urandom(20249));
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    fwd_data    = '0;
    invalidate  = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    check(160'(alu_valid), 160'(1'b0), "alu_valid after reset");
    check(160'(bru_valid), 160'(1'b0), "bru_valid after reset");
    check(160'(wb_valid), 160'(1'b0), "wb_valid after reset");
    check(160'(issue_ready), 160'(1'b1), "issue_ready after reset");

    for (int k = 0; k < n_alu; k++) begin
      ins         = rand_issue(unit_alu, 1'b0);
      ins.cmd.alu = alu_op_e'(4'(k % 8));  // Every op in turn
      issue_one(ins, $urandom, 1'b0);
    end
    drain();

    // Forwarding through both units
    repeat (n_fwd) issue_one(rand_issue($urandom_range(0, 1) == 1 ? unit_alu : unit_bru, 1'b1),
                             $urandom, 1'b0);
    drain();

    for (int k = 0; k <= 4; k++) begin
      for (int rel = 0; rel < 3; rel++) begin
        repeat (3) issue_one(make_branch(bru_op_e'(4'(k)), rel), $urandom, 1'b0);
      end
    end
    drain();

    // Back-pressure
    set_wb_mode(1);
    repeat (n_mix) issue_one(rand_issue(any_unit(), 1'b1), $urandom, 1'b0);
    drain();
    set_wb_mode(2);
    repeat (`WB_FIFO_DEPTH) issue_one(rand_issue(unit_none, 1'b0), $urandom, 1'b0);
    stop_issue();
    check(160'(issue_ready), 160'(1'b0), "issue_ready with full FIFO");
    check(160'(wb_valid), 160'(1'b1), "wb_valid with full FIFO");
    fork
      issue_one(rand_issue(unit_alu, 1'b0), $urandom, 1'b0);
      begin
        repeat (6) @(posedge clk);
        wb_mode = 1;
      end
    join
    repeat (n_mix) issue_one(rand_issue(any_unit(), 1'b1), $urandom, 1'b0);
    drain();

    // Invalidate with entries pending, then with a same-cycle issue
    set_wb_mode(2);
    repeat (3) issue_one(rand_issue(any_unit(), 1'b0), $urandom, 1'b0);
    pulse_invalidate();
    repeat (2) issue_one(rand_issue(unit_alu, 1'b0), $urandom, 1'b0);
    issue_one(rand_issue(unit_alu, 1'b0), $urandom, 1'b1);
    stop_issue();
    check(160'(wb_valid), 160'(1'b0), "wb_valid after invalidate with issue");
    set_wb_mode(0);
    repeat (6) issue_one(rand_issue(any_unit(), 1'b0), $urandom, 1'b0);
    drain();

    if (alu_q.size() != 0 || bru_q.size() != 0 || wb_q.size() != 0 || wb_valid) begin
      abort_run("Expected results still outstanding at end of run");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== src.f ====
+incdir+include
rtl/exec_pkg.sv
rtl/wb_fifo.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/dispatcher.sv
rtl/exec_stage.sv
bench/exec_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execute stage with its testbench in Verilator binary timing mode and run it
# The exit status is the simulator's, nonzero on any $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module exec_stage_tb -f src.f -o exec_sim \
  && ./obj_dir/exec_sim \
  || { echo "Simulation build or run failed" >&2; exit 1; }
